// ==== hdl/spidergon_pkg.sv ====
// router port numbering shared by the RTL and the testbench; NUM_PORTS must equal the enum size
package spidergon_pkg;

	// router port numbers, also the slice order of every per-port bus
	typedef enum logic [1:0] {
		port_anticlockwise = 2'd0,
		port_clockwise     = 2'd1,
		port_across        = 2'd2,
		port_local         = 2'd3
	} port_e;

	// three ring links plus the local inject/eject pair
	parameter int NUM_PORTS = 4;

endpackage

// ==== hdl/flit_fifo.sv ====
// two-entry input buffer; push_ready depends only on the fill count, so a full buffer takes no push
`timescale 1ns/1ps

module flit_fifo #(
	parameter int FLIT_WIDTH = 22
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [FLIT_WIDTH-1:0] push_flit,
	input  logic                  push_valid,
	output logic                  push_ready,
	output logic [FLIT_WIDTH-1:0] head_flit,
	output logic                  head_valid,
	input  logic                  pop
);

	logic [FLIT_WIDTH-1:0] mem [2];
	logic                  wr_ptr;
	logic                  rd_ptr;
	logic [1:0]            count;
	logic                  do_push;
	logic                  do_pop;

	// ready from count only, never from push_valid
	assign push_ready = (count != 2'd2);
	assign head_valid = (count != 2'd0);
	assign head_flit  = mem[rd_ptr];

	assign do_push = push_valid && push_ready;
	assign do_pop  = pop && head_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ~wr_ptr;
			if (do_pop)
				rd_ptr <= ~rd_ptr;
			// push and pop on one edge leave the count as it is
			count <= count + {1'b0, do_push} - {1'b0, do_pop};
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_flit;
	end

endmodule

// ==== hdl/route_compute.sv ====
// across-first output choice; NUM_NODES must be even and at least 4, other counts are not handled
`timescale 1ns/1ps

module route_compute #(
	parameter int NUM_NODES = 8,
	parameter int NODE_ID   = 0
)
(
	input  logic [$clog2(NUM_NODES)-1:0] dest,
	output spidergon_pkg::port_e         out_port
);

	// nodes within a quarter of the ring are reached along the ring
	localparam int QUARTER = NUM_NODES / 4;

	int rel;

	always_comb
	begin
		// distance in the clockwise direction
		rel = (int'(dest) + NUM_NODES - NODE_ID) % NUM_NODES;

		if (rel == 0)
			out_port = spidergon_pkg::port_local;
		else if (rel <= QUARTER)
			out_port = spidergon_pkg::port_clockwise;
		else if (rel >= NUM_NODES - QUARTER)
			out_port = spidergon_pkg::port_anticlockwise;
		else
			// far side, cross first and finish on the ring there
			out_port = spidergon_pkg::port_across;
	end

endmodule

// ==== hdl/switch_allocator.sv ====
// round-robin switch allocator; each input requests one output, so an input wins at most once
`timescale 1ns/1ps

module switch_allocator
(
	input  logic                                               clk,
	input  logic                                               reset,
	input  logic [spidergon_pkg::NUM_PORTS-1:0]                request_valid,
	input  spidergon_pkg::port_e [spidergon_pkg::NUM_PORTS-1:0] request_port,
	input  logic [spidergon_pkg::NUM_PORTS-1:0]                output_free,
	output logic [spidergon_pkg::NUM_PORTS-1:0]                grant,
	output spidergon_pkg::port_e [spidergon_pkg::NUM_PORTS-1:0] grant_source,
	output logic [spidergon_pkg::NUM_PORTS-1:0]                grant_any
);

	// last input that won each output
	spidergon_pkg::port_e last_winner [spidergon_pkg::NUM_PORTS];

	always_comb
	begin : grant_logic
		int cand;

		grant     = '0;
		grant_any = '0;
		for (int o = 0; o < spidergon_pkg::NUM_PORTS; o++)
		begin
			grant_source[o] = spidergon_pkg::port_anticlockwise;
		end

		for (int o = 0; o < spidergon_pkg::NUM_PORTS; o++)
		begin
			// scan starts just after the previous winner
			for (int k = 1; k <= spidergon_pkg::NUM_PORTS; k++)
			begin
				cand = (int'(last_winner[o]) + k) % spidergon_pkg::NUM_PORTS;
				if (output_free[o] && !grant_any[o] && request_valid[cand] &&
					request_port[cand] == spidergon_pkg::port_e'(o))
				begin
					grant_any[o]    = 1'b1;
					grant_source[o] = spidergon_pkg::port_e'(cand);
					grant[cand]     = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// first scan after reset begins at input 0
			for (int o = 0; o < spidergon_pkg::NUM_PORTS; o++)
			begin
				last_winner[o] <= spidergon_pkg::port_local;
			end
		end
		else
		begin
			for (int o = 0; o < spidergon_pkg::NUM_PORTS; o++)
			begin
				if (grant_any[o])
					last_winner[o] <= grant_source[o];
			end
		end
	end

endmodule

// ==== hdl/spidergon_node.sv ====
// one router with buffers, route logic, allocator and registered outputs; no U-turn check
`timescale 1ns/1ps

module spidergon_node #(
	parameter int  NUM_NODES     = 8,
	parameter int  PAYLOAD_WIDTH = 16,
	parameter int  NODE_ID       = 0,
	localparam int NODE_WIDTH    = $clog2(NUM_NODES),
	localparam int FLIT_WIDTH    = 2 * NODE_WIDTH + PAYLOAD_WIDTH
)
(
	input  logic                                           clk,
	input  logic                                           reset,
	input  logic [spidergon_pkg::NUM_PORTS*FLIT_WIDTH-1:0] in_flit,
	input  logic [spidergon_pkg::NUM_PORTS-1:0]            in_valid,
	output logic [spidergon_pkg::NUM_PORTS-1:0]            in_ready,
	output logic [spidergon_pkg::NUM_PORTS*FLIT_WIDTH-1:0] out_flit,
	output logic [spidergon_pkg::NUM_PORTS-1:0]            out_valid,
	input  logic [spidergon_pkg::NUM_PORTS-1:0]            out_ready
);

	// buffer heads and their requested outputs
	logic [FLIT_WIDTH-1:0]                              head_flit [spidergon_pkg::NUM_PORTS];
	logic [spidergon_pkg::NUM_PORTS-1:0]                head_valid;
	spidergon_pkg::port_e [spidergon_pkg::NUM_PORTS-1:0] route_port;

	// allocator results
	logic [spidergon_pkg::NUM_PORTS-1:0]                grant;
	spidergon_pkg::port_e [spidergon_pkg::NUM_PORTS-1:0] grant_source;
	logic [spidergon_pkg::NUM_PORTS-1:0]                grant_any;
	logic [spidergon_pkg::NUM_PORTS-1:0]                output_free;

	// crossbar outputs and the output registers
	logic [FLIT_WIDTH-1:0]                              xbar_flit [spidergon_pkg::NUM_PORTS];
	logic [FLIT_WIDTH-1:0]                              out_data [spidergon_pkg::NUM_PORTS];
	logic [spidergon_pkg::NUM_PORTS-1:0]                out_valid_r;

	for (genvar p = 0; p < spidergon_pkg::NUM_PORTS; p++)
	begin : g_port
		flit_fifo #(
			.FLIT_WIDTH (FLIT_WIDTH)
		)
		fifo_i
		(
			.clk        (clk),
			.reset      (reset),
			.push_flit  (in_flit[p*FLIT_WIDTH +: FLIT_WIDTH]),
			.push_valid (in_valid[p]),
			.push_ready (in_ready[p]),
			.head_flit  (head_flit[p]),
			.head_valid (head_valid[p]),
			.pop        (grant[p])
		);

		// destination sits in the top bits of the flit
		route_compute #(
			.NUM_NODES (NUM_NODES),
			.NODE_ID   (NODE_ID)
		)
		route_i
		(
			.dest     (head_flit[p][FLIT_WIDTH-1 -: NODE_WIDTH]),
			.out_port (route_port[p])
		);

		// crossbar column for output p
		assign xbar_flit[p] = head_flit[grant_source[p]];

		assign out_flit[p*FLIT_WIDTH +: FLIT_WIDTH] = out_data[p];
	end

	// a register may take a new flit when empty or drained on the same edge
	assign output_free = ~out_valid_r | out_ready;
	assign out_valid   = out_valid_r;

	switch_allocator alloc_i
	(
		.clk           (clk),
		.reset         (reset),
		.request_valid (head_valid),
		.request_port  (route_port),
		.output_free   (output_free),
		.grant         (grant),
		.grant_source  (grant_source),
		.grant_any     (grant_any)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid_r <= '0;
		else
		begin
			for (int p = 0; p < spidergon_pkg::NUM_PORTS; p++)
			begin
				if (grant_any[p])
					out_valid_r[p] <= 1'b1;
				else if (out_ready[p])
					out_valid_r[p] <= 1'b0;
			end
		end
	end

	// load happens on the edge that pops the input buffer
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < spidergon_pkg::NUM_PORTS; p++)
		begin
			if (grant_any[p])
				out_data[p] <= xbar_flit[p];
		end
	end

endmodule

// ==== hdl/spidergon_noc.sv ====
// single-channel links can deadlock the ring under saturating traffic; NUM_NODES even and >= 4
`timescale 1ns/1ps

module spidergon_noc #(
	parameter int  NUM_NODES     = 8,
	parameter int  PAYLOAD_WIDTH = 16,
	localparam int NODE_WIDTH    = $clog2(NUM_NODES),
	localparam int FLIT_WIDTH    = 2 * NODE_WIDTH + PAYLOAD_WIDTH
)
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic [NUM_NODES*FLIT_WIDTH-1:0] inject_flit,
	input  logic [NUM_NODES-1:0]            inject_valid,
	output logic [NUM_NODES-1:0]            inject_ready,
	output logic [NUM_NODES*FLIT_WIDTH-1:0] eject_flit,
	output logic [NUM_NODES-1:0]            eject_valid,
	input  logic [NUM_NODES-1:0]            eject_ready
);

	localparam int ACW = int'(spidergon_pkg::port_anticlockwise);
	localparam int CW  = int'(spidergon_pkg::port_clockwise);
	localparam int AX  = int'(spidergon_pkg::port_across);
	localparam int LOC = int'(spidergon_pkg::port_local);
	localparam int PW  = spidergon_pkg::NUM_PORTS * FLIT_WIDTH;

	// per-node port buses, driven bit by bit from the link wiring below
	wire [PW-1:0]                       node_in_flit   [NUM_NODES];
	wire [spidergon_pkg::NUM_PORTS-1:0] node_in_valid  [NUM_NODES];
	wire [spidergon_pkg::NUM_PORTS-1:0] node_in_ready  [NUM_NODES];
	wire [PW-1:0]                       node_out_flit  [NUM_NODES];
	wire [spidergon_pkg::NUM_PORTS-1:0] node_out_valid [NUM_NODES];
	wire [spidergon_pkg::NUM_PORTS-1:0] node_out_ready [NUM_NODES];

	for (genvar n = 0; n < NUM_NODES; n++)
	begin : g_node
		localparam int PREV = (n + NUM_NODES - 1) % NUM_NODES;
		localparam int NEXT = (n + 1) % NUM_NODES;
		localparam int OPP  = (n + NUM_NODES / 2) % NUM_NODES;

		// clockwise output of n-1 arrives on our anticlockwise input
		assign node_in_flit[n][ACW*FLIT_WIDTH +: FLIT_WIDTH] =
			node_out_flit[PREV][CW*FLIT_WIDTH +: FLIT_WIDTH];
		assign node_in_valid[n][ACW]    = node_out_valid[PREV][CW];
		assign node_out_ready[PREV][CW] = node_in_ready[n][ACW];

		// anticlockwise output of n+1 arrives on our clockwise input
		assign node_in_flit[n][CW*FLIT_WIDTH +: FLIT_WIDTH] =
			node_out_flit[NEXT][ACW*FLIT_WIDTH +: FLIT_WIDTH];
		assign node_in_valid[n][CW]      = node_out_valid[NEXT][ACW];
		assign node_out_ready[NEXT][ACW] = node_in_ready[n][CW];

		// across link pairs n with n +/- NUM_NODES/2
		assign node_in_flit[n][AX*FLIT_WIDTH +: FLIT_WIDTH] =
			node_out_flit[OPP][AX*FLIT_WIDTH +: FLIT_WIDTH];
		assign node_in_valid[n][AX]    = node_out_valid[OPP][AX];
		assign node_out_ready[OPP][AX] = node_in_ready[n][AX];

		// local inject and eject
		assign node_in_flit[n][LOC*FLIT_WIDTH +: FLIT_WIDTH] =
			inject_flit[n*FLIT_WIDTH +: FLIT_WIDTH];
		assign node_in_valid[n][LOC]  = inject_valid[n];
		assign inject_ready[n]        = node_in_ready[n][LOC];
		assign eject_flit[n*FLIT_WIDTH +: FLIT_WIDTH] =
			node_out_flit[n][LOC*FLIT_WIDTH +: FLIT_WIDTH];
		assign eject_valid[n]         = node_out_valid[n][LOC];
		assign node_out_ready[n][LOC] = eject_ready[n];

		spidergon_node #(
			.NUM_NODES     (NUM_NODES),
			.PAYLOAD_WIDTH (PAYLOAD_WIDTH),
			.NODE_ID       (n)
		)
		node_i
		(
			.clk       (clk),
			.reset     (reset),
			.in_flit   (node_in_flit[n]),
			.in_valid  (node_in_valid[n]),
			.in_ready  (node_in_ready[n]),
			.out_flit  (node_out_flit[n]),
			.out_valid (node_out_valid[n]),
			.out_ready (node_out_ready[n])
		);
	end

endmodule

// ==== test/tb_spidergon_noc.sv ====
// default 8-node build only; load stays bounded since a single-channel ring can deadlock
`timescale 1ns/1ps

module tb_spidergon_noc;

	localparam int NUM_NODES     = 8;
	localparam int PAYLOAD_WIDTH = 16;
	localparam int NODE_WIDTH    = $clog2(NUM_NODES);
	localparam int FLIT_WIDTH    = 2 * NODE_WIDTH + PAYLOAD_WIDTH;
	localparam int MAX_ENTRIES   = 96;
	localparam int DRAIN_CYCLES  = 16;

	logic                            clk;
	logic                            reset;
	logic [NUM_NODES*FLIT_WIDTH-1:0] inject_flit;
	logic [NUM_NODES-1:0]            inject_valid;
	logic [NUM_NODES-1:0]            inject_ready;
	logic [NUM_NODES*FLIT_WIDTH-1:0] eject_flit;
	logic [NUM_NODES-1:0]            eject_valid;
	logic [NUM_NODES-1:0]            eject_ready;

	// stimulus table, one row per packet
	int                       tbl_test    [MAX_ENTRIES];
	int                       tbl_src     [MAX_ENTRIES];
	int                       tbl_dst     [MAX_ENTRIES];
	int                       tbl_issue   [MAX_ENTRIES];
	int                       tbl_hold    [MAX_ENTRIES];
	logic [PAYLOAD_WIDTH-1:0] tbl_payload [MAX_ENTRIES];
	int                       tbl_len;

	// pending table rows per source and expected flits per destination
	int                    src_queue     [NUM_NODES][$];
	logic [FLIT_WIDTH-1:0] expect_queue  [NUM_NODES][$];
	int                    release_cycle [NUM_NODES];

	logic [31:0] lfsr_state;
	int          cycle;
	int          test_start;
	int          cycle_limit = 0;
	int          timeout_cycles;
	int          error_count;
	int          checks_done;
	int          arrivals;

	spidergon_noc #(
		.NUM_NODES     (NUM_NODES),
		.PAYLOAD_WIDTH (PAYLOAD_WIDTH)
	)
	dut_i
	(
		.clk          (clk),
		.reset        (reset),
		.inject_flit  (inject_flit),
		.inject_valid (inject_valid),
		.inject_ready (inject_ready),
		.eject_flit   (eject_flit),
		.eject_valid  (eject_valid),
		.eject_ready  (eject_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// fibonacci form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// destination on top, then source, then payload
	function automatic logic [FLIT_WIDTH-1:0] make_flit(input int dst, input int src,
		input logic [PAYLOAD_WIDTH-1:0] payload);
		return {NODE_WIDTH'(dst), NODE_WIDTH'(src), payload};
	endfunction

	task automatic check_flit(input logic [FLIT_WIDTH-1:0] got,
		input logic [FLIT_WIDTH-1:0] exp, input string what);
		checks_done++;
		if (got !== exp)
		begin
			error_count++;
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks_done++;
		if (got != exp)
		begin
			error_count++;
			$display("ERROR at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_mask(input logic [NUM_NODES-1:0] got,
		input logic [NUM_NODES-1:0] exp, input string what);
		checks_done++;
		if (got !== exp)
		begin
			error_count++;
			$display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic add_entry(input int test, input int src, input int dst, input int issue,
		input int hold);
		logic [31:0] bits;
		take_bits(PAYLOAD_WIDTH, bits);
		tbl_test[tbl_len]    = test;
		tbl_src[tbl_len]     = src;
		tbl_dst[tbl_len]     = dst;
		tbl_issue[tbl_len]   = issue;
		tbl_hold[tbl_len]    = hold;
		tbl_payload[tbl_len] = bits[PAYLOAD_WIDTH-1:0];
		tbl_len++;
	endtask

	task automatic build_table();
		logic [31:0] bits;
		tbl_len    = 0;
		lfsr_state = 32'hec54da6b;
		// node 0 to every node covers local, ring and across paths
		for (int d = 0; d < NUM_NODES; d++)
			add_entry(2, 0, d, 2 * d, 0);
		add_entry(3, 3, 3, 0, 0);
		add_entry(3, 6, 6, 0, 0);
		// three input directions into node 5 while its eject port is stalled
		for (int k = 0; k < 4; k++)
		begin
			add_entry(4, 4, 5, k, 40);
			add_entry(4, 6, 5, k, 40);
			add_entry(4, 1, 5, k, 40);
		end
		// mixed pairs with one packet per source every 4 cycles
		for (int k = 0; k < 6; k++)
		begin
			for (int s = 0; s < NUM_NODES; s++)
			begin
				take_bits(NODE_WIDTH, bits);
				add_entry(5, s, int'(bits[NODE_WIDTH-1:0]), 4 * k, 0);
			end
		end
	endtask

	task automatic load_test(input int t, output int count);
		count = 0;
		for (int n = 0; n < NUM_NODES; n++)
			release_cycle[n] = 0;
		for (int i = 0; i < tbl_len; i++)
		begin
			if (tbl_test[i] == t)
			begin
				src_queue[tbl_src[i]].push_back(i);
				expect_queue[tbl_dst[i]].push_back(
					make_flit(tbl_dst[i], tbl_src[i], tbl_payload[i]));
				if (tbl_hold[i] > release_cycle[tbl_dst[i]])
					release_cycle[tbl_dst[i]] = tbl_hold[i];
				count++;
			end
		end
		test_start = cycle;
		for (int n = 0; n < NUM_NODES; n++)
			eject_ready[n] = (release_cycle[n] == 0);
	endtask

	task automatic match_arrival(input int node, input logic [FLIT_WIDTH-1:0] got);
		logic [FLIT_WIDTH-1:0] entry;
		int                    hit;
		hit = -1;
		// oldest pending flit of the same source keeps per-pair order
		for (int i = 0; i < expect_queue[node].size(); i++)
		begin
			entry = expect_queue[node][i];
			if (hit < 0 &&
				entry[PAYLOAD_WIDTH +: NODE_WIDTH] == got[PAYLOAD_WIDTH +: NODE_WIDTH])
				hit = i;
		end
		if (hit < 0)
		begin
			error_count++;
			$display("ERROR at %0t: unexpected flit %h at node %0d", $time, got, node);
		end
		else
		begin
			check_flit(got, expect_queue[node][hit], $sformatf("eject node %0d", node));
			expect_queue[node].delete(hit);
		end
	endtask

	task automatic drive_inputs(input logic [NUM_NODES-1:0] done);
		int idx;
		for (int s = 0; s < NUM_NODES; s++)
		begin
			if (done[s])
			begin
				inject_valid[s] = 1'b0;
				void'(src_queue[s].pop_front());
			end
			if (!inject_valid[s] && src_queue[s].size() > 0)
			begin
				idx = src_queue[s][0];
				if (cycle - test_start >= tbl_issue[idx])
				begin
					inject_flit[s*FLIT_WIDTH +: FLIT_WIDTH] =
						make_flit(tbl_dst[idx], tbl_src[idx], tbl_payload[idx]);
					inject_valid[s] = 1'b1;
				end
			end
			eject_ready[s] = (cycle - test_start >= release_cycle[s]);
		end
	endtask

	// samples at the falling edge; a handshake seen there completes on the next rising edge
	task automatic step_cycle(output int arrived);
		logic [NUM_NODES-1:0] inject_done;
		arrived = 0;
		@(negedge clk);
		inject_done = inject_valid & inject_ready;
		for (int n = 0; n < NUM_NODES; n++)
		begin
			if (release_cycle[n] > 0 && cycle - test_start == release_cycle[n])
				check_count(int'(eject_valid[n]), 1, $sformatf("held eject valid node %0d", n));
			if (eject_valid[n] && eject_ready[n])
			begin
				match_arrival(n, eject_flit[n*FLIT_WIDTH +: FLIT_WIDTH]);
				arrived++;
				arrivals++;
			end
		end
		@(posedge clk);
		cycle++;
		#2;
		drive_inputs(inject_done);
	endtask

	function automatic bit test_idle();
		bit idle;
		idle = (inject_valid == '0);
		for (int n = 0; n < NUM_NODES; n++)
		begin
			if (src_queue[n].size() != 0 || expect_queue[n].size() != 0)
				idle = 1'b0;
		end
		return idle;
	endfunction

	task automatic run_test(input int t, input string name);
		int expected;
		int got;
		int arrived;
		int start_errors;
		start_errors = error_count;
		got = 0;
		load_test(t, expected);
		while (!test_idle())
		begin
			step_cycle(arrived);
			got += arrived;
		end
		// quiet window where any late or duplicated flit still shows up
		repeat (DRAIN_CYCLES)
		begin
			step_cycle(arrived);
			got += arrived;
		end
		check_count(got, expected, $sformatf("test %0d arrivals", t));
		$display("test %0d %s: %0d of %0d packets, %0d errors", t, name, got, expected,
			error_count - start_errors);
	endtask

	initial
	begin : watchdog
		timeout_cycles = 0;
		@(posedge clk);
		while (cycle_limit == 0 || timeout_cycles < cycle_limit)
		begin
			@(posedge clk);
			timeout_cycles++;
		end
		$display("timeout after %0d cycles, packets still in flight", timeout_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		reset        = 1'b1;
		inject_flit  = '0;
		inject_valid = '0;
		eject_ready  = '1;
		cycle        = 0;
		test_start   = 0;
		error_count  = 0;
		checks_done  = 0;
		arrivals     = 0;
		for (int n = 0; n < NUM_NODES; n++)
			release_cycle[n] = 0;
		build_table();
		cycle_limit = tbl_len * 64 + 500;

		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_mask(inject_ready, '1, "inject_ready after reset");
		check_mask(eject_valid, '0, "eject_valid after reset");
		$display("test 1 reset state: %0d errors", error_count);
		@(posedge clk);
		#2;

		run_test(2, "node 0 to every node");
		run_test(3, "own node delivery");
		run_test(4, "eject back-pressure");
		run_test(5, "mixed traffic");

		check_count(arrivals, tbl_len, "total arrivals");
		$display("checks %0d, errors %0d, arrivals %0d of %0d", checks_done, error_count,
			arrivals, tbl_len);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== spidergon_noc.f ====
hdl/spidergon_pkg.sv
hdl/flit_fifo.sv
hdl/route_compute.sv
hdl/switch_allocator.sv
hdl/spidergon_node.sv
hdl/spidergon_noc.sv
test/tb_spidergon_noc.sv

// ==== Bender.yml ====
package:
  name: spidergon_noc

sources:
  # RTL in compile order
  - files:
      - hdl/spidergon_pkg.sv
      - hdl/flit_fifo.sv
      - hdl/route_compute.sv
      - hdl/switch_allocator.sv
      - hdl/spidergon_node.sv
      - hdl/spidergon_noc.sv
  # testbench
  - target: test
    files:
      - test/tb_spidergon_noc.sv
